//--- logic/mc_adapter_pkg.sv
// Memory controller adapter definitions

package mc_adapter_pkg;

	// Sizes and counts
	localparam int NUM_MC_PORTS = 4;
	localparam int TID_W = 32;
	localparam int ADDR_W = 48;
	localparam int DATA_W = 64;
	// Quadword count carried in the low id bits
	localparam int QW_W = 3;

	// Field types
	typedef logic [TID_W-1:0] tid_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [1:0] size_t;
	typedef logic [2:0] mc_cmd_t;
	typedef logic [3:0] mc_scmd_t;
	typedef logic [1:0] req_kind_t;

	// Internal request kinds
	// Kind 2 falls into the atomic decode as well
	localparam req_kind_t REQ_READ = 2'd0;
	localparam req_kind_t REQ_WRITE = 2'd1;
	localparam req_kind_t REQ_ATOMIC = 2'd3;

	// Request commands toward the memory controller
	localparam mc_cmd_t CMD_RD8 = 3'd1;
	localparam mc_cmd_t CMD_WR8 = 3'd2;
	localparam mc_cmd_t CMD_RD64 = 3'd3;
	localparam mc_cmd_t CMD_WR64 = 3'd4;
	localparam mc_cmd_t CMD_ATOMIC = 3'd6;

	// Response commands from the memory controller
	localparam mc_cmd_t RSP_RD8_DATA = 3'd2;
	localparam mc_cmd_t RSP_WR_CMP = 3'd3;
	localparam mc_cmd_t RSP_ATOMIC_DATA = 3'd4;
	localparam mc_cmd_t RSP_WR64_CMP = 3'd5;
	localparam mc_cmd_t RSP_RD64_DATA = 3'd7;

	// Atomic exchange sub-command
	localparam mc_scmd_t SCMD_ATOM_EXCH = 4'd2;

	// Exchange operand with only the top bit set
	localparam data_t ATOM_EXCH_DATA = {1'b1, {(DATA_W-1){1'b0}}};

endpackage

//--- logic/mc_req_encoder.sv
// Memory controller request encoder

module mc_req_encoder (
	// Internal request
	input  logic                      i_req_vld,
	input  mc_adapter_pkg::req_kind_t i_req_kind,
	input  mc_adapter_pkg::size_t     i_req_size,
	input  mc_adapter_pkg::tid_t      i_req_tid,
	input  mc_adapter_pkg::addr_t     i_req_addr,
	input  mc_adapter_pkg::data_t     i_req_data,

	// Memory controller request fields
	output logic                      o_mc_rq_vld,
	output mc_adapter_pkg::tid_t      o_mc_rq_rtnctl,
	output mc_adapter_pkg::data_t     o_mc_rq_data,
	output mc_adapter_pkg::addr_t     o_mc_rq_vadr,
	output mc_adapter_pkg::size_t     o_mc_rq_size,
	output mc_adapter_pkg::mc_cmd_t   o_mc_rq_cmd,
	output mc_adapter_pkg::mc_scmd_t  o_mc_rq_scmd
);

	import mc_adapter_pkg::*;

	logic [QW_W-1:0] qw_cnt;
	logic [QW_W-1:0] qw_cnt_inc;
	logic            is_64b;

	// Low id bits hold the quadword count of the transfer
	assign qw_cnt = i_req_tid[QW_W-1:0];
	assign is_64b = |qw_cnt;

	// Wraps at eight, so a full line encodes as zero
	assign qw_cnt_inc = qw_cnt + 1'b1;

	// Unchanged fields
	assign o_mc_rq_vld = i_req_vld;
	assign o_mc_rq_rtnctl = i_req_tid;
	assign o_mc_rq_vadr = i_req_addr;
	assign o_mc_rq_size = i_req_size;

	// Command select
	always_comb begin
		case (i_req_kind)
			REQ_READ: begin
				o_mc_rq_cmd = is_64b ? CMD_RD64 : CMD_RD8;
			end
			REQ_WRITE: begin
				o_mc_rq_cmd = is_64b ? CMD_WR64 : CMD_WR8;
			end
			default: begin
				o_mc_rq_cmd = CMD_ATOMIC;
			end
		endcase
	end

	// Sub-command follows the chosen command
	always_comb begin
		case (o_mc_rq_cmd)
			CMD_WR64: begin
				o_mc_rq_scmd = mc_scmd_t'(qw_cnt_inc);
			end
			CMD_ATOMIC: begin
				o_mc_rq_scmd = SCMD_ATOM_EXCH;
			end
			default: begin
				o_mc_rq_scmd = '0;
			end
		endcase
	end

	// Exchange operand replaces the payload for kind 3 only
	assign o_mc_rq_data = (i_req_kind == REQ_ATOMIC) ? ATOM_EXCH_DATA : i_req_data;

endmodule

//--- logic/mc_rsp_decoder.sv
// Memory controller response decoder

module mc_rsp_decoder (
	// Memory controller response fields
	input  logic                     i_mc_rs_vld,
	input  mc_adapter_pkg::mc_cmd_t  i_mc_rs_cmd,
	input  mc_adapter_pkg::mc_scmd_t i_mc_rs_scmd,
	input  mc_adapter_pkg::data_t    i_mc_rs_data,
	input  mc_adapter_pkg::tid_t     i_mc_rs_rtnctl,

	// Internal response queue levels
	input  logic                     i_rd_rsp_full,
	input  logic                     i_wr_rsp_full,

	// Internal responses
	output logic                     o_rd_rsp_vld,
	output mc_adapter_pkg::tid_t     o_rd_rsp_tid,
	output mc_adapter_pkg::data_t    o_rd_rsp_data,
	output logic                     o_wr_rsp_vld,
	output mc_adapter_pkg::tid_t     o_wr_rsp_tid,
	output logic                     o_mc_rs_stall
);

	import mc_adapter_pkg::*;

	logic            is_rd;
	logic            is_wr;
	logic [QW_W-1:0] qw_idx;

	// Response classification
	always_comb begin
		is_rd = 1'b0;
		is_wr = 1'b0;
		case (i_mc_rs_cmd)
			RSP_RD8_DATA, RSP_RD64_DATA, RSP_ATOMIC_DATA: begin
				is_rd = 1'b1;
			end
			RSP_WR_CMP, RSP_WR64_CMP: begin
				is_wr = 1'b1;
			end
			default: begin
				is_rd = 1'b0;
			end
		endcase
	end

	assign o_rd_rsp_vld = i_mc_rs_vld && is_rd;
	assign o_wr_rsp_vld = i_mc_rs_vld && is_wr;

	// Only 64-byte reads return a quadword index in scmd
	assign qw_idx = (i_mc_rs_cmd == RSP_RD64_DATA) ? i_mc_rs_scmd[QW_W-1:0] : '0;

	assign o_rd_rsp_tid = {i_mc_rs_rtnctl[TID_W-1:QW_W], qw_idx};
	assign o_rd_rsp_data = i_mc_rs_data;
	assign o_wr_rsp_tid = i_mc_rs_rtnctl;

	// Hold off the controller if either queue is full
	assign o_mc_rs_stall = i_rd_rsp_full || i_wr_rsp_full;

endmodule

//--- logic/mc_port_adapter.sv
// Memory controller port adapter

module mc_port_adapter (
	// Internal requests
	input  logic                      i_req_vld      [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::req_kind_t i_req_kind     [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::size_t     i_req_size     [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::tid_t      i_req_tid      [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::addr_t     i_req_addr     [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::data_t     i_req_data     [mc_adapter_pkg::NUM_MC_PORTS],
	output logic                      o_req_full     [mc_adapter_pkg::NUM_MC_PORTS],

	// Memory controller requests
	output logic                      o_mc_rq_vld    [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::tid_t      o_mc_rq_rtnctl [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::data_t     o_mc_rq_data   [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::addr_t     o_mc_rq_vadr   [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::size_t     o_mc_rq_size   [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::mc_cmd_t   o_mc_rq_cmd    [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::mc_scmd_t  o_mc_rq_scmd   [mc_adapter_pkg::NUM_MC_PORTS],
	input  logic                      i_mc_rq_stall  [mc_adapter_pkg::NUM_MC_PORTS],

	// Memory controller responses
	input  logic                      i_mc_rs_vld    [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::mc_cmd_t   i_mc_rs_cmd    [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::mc_scmd_t  i_mc_rs_scmd   [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::data_t     i_mc_rs_data   [mc_adapter_pkg::NUM_MC_PORTS],
	input  mc_adapter_pkg::tid_t      i_mc_rs_rtnctl [mc_adapter_pkg::NUM_MC_PORTS],
	output logic                      o_mc_rs_stall  [mc_adapter_pkg::NUM_MC_PORTS],

	// Internal responses
	output logic                      o_rd_rsp_vld   [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::tid_t      o_rd_rsp_tid   [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::data_t     o_rd_rsp_data  [mc_adapter_pkg::NUM_MC_PORTS],
	input  logic                      i_rd_rsp_full  [mc_adapter_pkg::NUM_MC_PORTS],
	output logic                      o_wr_rsp_vld   [mc_adapter_pkg::NUM_MC_PORTS],
	output mc_adapter_pkg::tid_t      o_wr_rsp_tid   [mc_adapter_pkg::NUM_MC_PORTS],
	input  logic                      i_wr_rsp_full  [mc_adapter_pkg::NUM_MC_PORTS]
);

	import mc_adapter_pkg::*;

	// One independent request and response path per port
	for (genvar p = 0; p < NUM_MC_PORTS; p++) begin : g_port

		// Request stall goes straight back to the personality
		assign o_req_full[p] = i_mc_rq_stall[p];

		mc_req_encoder u_req_enc (
			.i_req_vld      (i_req_vld[p]),
			.i_req_kind     (i_req_kind[p]),
			.i_req_size     (i_req_size[p]),
			.i_req_tid      (i_req_tid[p]),
			.i_req_addr     (i_req_addr[p]),
			.i_req_data     (i_req_data[p]),
			.o_mc_rq_vld    (o_mc_rq_vld[p]),
			.o_mc_rq_rtnctl (o_mc_rq_rtnctl[p]),
			.o_mc_rq_data   (o_mc_rq_data[p]),
			.o_mc_rq_vadr   (o_mc_rq_vadr[p]),
			.o_mc_rq_size   (o_mc_rq_size[p]),
			.o_mc_rq_cmd    (o_mc_rq_cmd[p]),
			.o_mc_rq_scmd   (o_mc_rq_scmd[p])
		);

		mc_rsp_decoder u_rsp_dec (
			.i_mc_rs_vld    (i_mc_rs_vld[p]),
			.i_mc_rs_cmd    (i_mc_rs_cmd[p]),
			.i_mc_rs_scmd   (i_mc_rs_scmd[p]),
			.i_mc_rs_data   (i_mc_rs_data[p]),
			.i_mc_rs_rtnctl (i_mc_rs_rtnctl[p]),
			.i_rd_rsp_full  (i_rd_rsp_full[p]),
			.i_wr_rsp_full  (i_wr_rsp_full[p]),
			.o_rd_rsp_vld   (o_rd_rsp_vld[p]),
			.o_rd_rsp_tid   (o_rd_rsp_tid[p]),
			.o_rd_rsp_data  (o_rd_rsp_data[p]),
			.o_wr_rsp_vld   (o_wr_rsp_vld[p]),
			.o_wr_rsp_tid   (o_wr_rsp_tid[p]),
			.o_mc_rs_stall  (o_mc_rs_stall[p])
		);

	end

endmodule

//--- verification/mc_ref_model.svh
// Reference model and compare tasks
`ifndef MC_REF_MODEL_SVH
`define MC_REF_MODEL_SVH

	// Request command from kind and quadword count
	function automatic mc_cmd_t exp_rq_cmd(input req_kind_t kind, input tid_t tid);
		logic multi_qw;
		multi_qw = (tid % 8) != 0;
		if (kind == 2'd0)
			return multi_qw ? CMD_RD64 : CMD_RD8;
		if (kind == 2'd1)
			return multi_qw ? CMD_WR64 : CMD_WR8;
		return CMD_ATOMIC;
	endfunction

	// Long writes carry the quadword count plus one as sub-command
	function automatic mc_scmd_t exp_rq_scmd(input req_kind_t kind, input tid_t tid);
		int qw;
		qw = int'(tid % 8);
		if (kind == 2'd1 && qw != 0)
			return mc_scmd_t'((qw + 1) % 8);
		if (kind[1])
			return 4'd2;
		return 4'd0;
	endfunction

	// Kind 3 carries the fixed exchange word
	function automatic data_t exp_rq_data(input req_kind_t kind, input data_t data);
		return (kind == 2'd3) ? 64'h8000_0000_0000_0000 : data;
	endfunction

	function automatic logic exp_rd_vld(input logic vld, input mc_cmd_t cmd);
		return vld && (cmd == 3'd2 || cmd == 3'd4 || cmd == 3'd7);
	endfunction

	function automatic logic exp_wr_vld(input logic vld, input mc_cmd_t cmd);
		return vld && (cmd == 3'd3 || cmd == 3'd5);
	endfunction

	// Quadword index only for 64-byte read data
	function automatic tid_t exp_rd_tid(input mc_cmd_t cmd, input mc_scmd_t scmd,
			input tid_t rtnctl);
		tid_t tid;
		tid = rtnctl;
		tid[2:0] = (cmd == 3'd7) ? scmd[2:0] : 3'd0;
		return tid;
	endfunction

	task automatic check_cmd(input string name, input mc_cmd_t exp, input mc_cmd_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_scmd(input string name, input mc_scmd_t exp, input mc_scmd_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_tid(input string name, input tid_t exp, input tid_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_size(input string name, input size_t exp, input size_t act);
		if (exp !== act) begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error %s: expected %0b, actual %0b", name, exp, act);
			test_errs++;
		end
	endtask

`endif

//--- verification/tb_mc_port_adapter.sv
// Port adapter testbench

module tb_mc_port_adapter;

	import mc_adapter_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 5;
	localparam int NUM_TESTS = 5;
	localparam int NUM_VEC = 64;
	localparam int MARGIN = 32;

	logic   clk;
	logic   i_rst_n;
	integer seed;
	int     test_errs;
	int     total_errs;
	int     tests_failed;
	logic   chk_en;
	string  test_name;
	string  names [NUM_TESTS] = '{"reads", "writes", "atomics", "responses", "backpressure"};

	logic      i_req_vld      [NUM_MC_PORTS];
	req_kind_t i_req_kind     [NUM_MC_PORTS];
	size_t     i_req_size     [NUM_MC_PORTS];
	tid_t      i_req_tid      [NUM_MC_PORTS];
	addr_t     i_req_addr     [NUM_MC_PORTS];
	data_t     i_req_data     [NUM_MC_PORTS];
	logic      o_req_full     [NUM_MC_PORTS];
	logic      o_mc_rq_vld    [NUM_MC_PORTS];
	tid_t      o_mc_rq_rtnctl [NUM_MC_PORTS];
	data_t     o_mc_rq_data   [NUM_MC_PORTS];
	addr_t     o_mc_rq_vadr   [NUM_MC_PORTS];
	size_t     o_mc_rq_size   [NUM_MC_PORTS];
	mc_cmd_t   o_mc_rq_cmd    [NUM_MC_PORTS];
	mc_scmd_t  o_mc_rq_scmd   [NUM_MC_PORTS];
	logic      i_mc_rq_stall  [NUM_MC_PORTS];
	logic      i_mc_rs_vld    [NUM_MC_PORTS];
	mc_cmd_t   i_mc_rs_cmd    [NUM_MC_PORTS];
	mc_scmd_t  i_mc_rs_scmd   [NUM_MC_PORTS];
	data_t     i_mc_rs_data   [NUM_MC_PORTS];
	tid_t      i_mc_rs_rtnctl [NUM_MC_PORTS];
	logic      o_mc_rs_stall  [NUM_MC_PORTS];
	logic      o_rd_rsp_vld   [NUM_MC_PORTS];
	tid_t      o_rd_rsp_tid   [NUM_MC_PORTS];
	data_t     o_rd_rsp_data  [NUM_MC_PORTS];
	logic      i_rd_rsp_full  [NUM_MC_PORTS];
	logic      o_wr_rsp_vld   [NUM_MC_PORTS];
	tid_t      o_wr_rsp_tid   [NUM_MC_PORTS];
	logic      i_wr_rsp_full  [NUM_MC_PORTS];

	`include "mc_ref_model.svh"

	mc_port_adapter u_dut (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	task automatic set_idle();
		for (int p = 0; p < NUM_MC_PORTS; p++) begin
			i_req_vld[p] = 1'b0;
			i_req_kind[p] = '0;
			i_req_size[p] = '0;
			i_req_tid[p] = '0;
			i_req_addr[p] = '0;
			i_req_data[p] = '0;
			i_mc_rq_stall[p] = 1'b0;
			i_mc_rs_vld[p] = 1'b0;
			i_mc_rs_cmd[p] = '0;
			i_mc_rs_scmd[p] = '0;
			i_mc_rs_data[p] = '0;
			i_mc_rs_rtnctl[p] = '0;
			i_rd_rsp_full[p] = 1'b0;
			i_wr_rsp_full[p] = 1'b0;
		end
	endtask

	// Random vector for one port narrowed to the test's focus
	task automatic drive_port(input int t, input int v, input int p);
		logic [31:0] r;
		r = next_rand();
		i_req_vld[p] = r[0];
		i_req_size[p] = r[2:1];
		i_mc_rq_stall[p] = r[3];
		i_mc_rs_vld[p] = r[4];
		i_rd_rsp_full[p] = r[5];
		i_wr_rsp_full[p] = r[6];
		i_req_kind[p] = r[8:7];
		i_mc_rs_cmd[p] = r[11:9];
		i_mc_rs_scmd[p] = r[15:12];
		i_req_tid[p] = next_rand();
		// Single quadword often enough to hit the 8-byte commands
		if (r[16])
			i_req_tid[p][2:0] = 3'd0;
		i_mc_rs_rtnctl[p] = next_rand();
		i_req_addr[p] = addr_t'({next_rand(), next_rand()});
		i_req_data[p] = {next_rand(), next_rand()};
		i_mc_rs_data[p] = {next_rand(), next_rand()};
		case (t)
			0: i_req_kind[p] = 2'd0;
			1: i_req_kind[p] = 2'd1;
			2: i_req_kind[p] = {1'b1, r[17]};
			3: begin
				// Walk every response code on every port
				i_mc_rs_cmd[p] = mc_cmd_t'(v + p);
				i_mc_rs_vld[p] = r[4] || ((v % 16) < 8);
			end
			default: ;
		endcase
	endtask

	task automatic check_idle(input int p);
		string tag;
		tag = $sformatf("%s port %0d", test_name, p);
		check_flag({tag, " rq_vld"}, 1'b0, o_mc_rq_vld[p]);
		check_flag({tag, " req_full"}, 1'b0, o_req_full[p]);
		check_flag({tag, " rd_vld"}, 1'b0, o_rd_rsp_vld[p]);
		check_flag({tag, " wr_vld"}, 1'b0, o_wr_rsp_vld[p]);
		check_flag({tag, " rs_stall"}, 1'b0, o_mc_rs_stall[p]);
	endtask

	task automatic check_port(input int p);
		string tag;
		tag = $sformatf("%s port %0d", test_name, p);
		check_flag({tag, " rq_vld"}, i_req_vld[p], o_mc_rq_vld[p]);
		check_tid({tag, " rtnctl"}, i_req_tid[p], o_mc_rq_rtnctl[p]);
		check_addr({tag, " vadr"}, i_req_addr[p], o_mc_rq_vadr[p]);
		check_size({tag, " size"}, i_req_size[p], o_mc_rq_size[p]);
		check_cmd({tag, " cmd"}, exp_rq_cmd(i_req_kind[p], i_req_tid[p]), o_mc_rq_cmd[p]);
		check_scmd({tag, " scmd"}, exp_rq_scmd(i_req_kind[p], i_req_tid[p]), o_mc_rq_scmd[p]);
		check_data({tag, " rq_data"}, exp_rq_data(i_req_kind[p], i_req_data[p]),
			o_mc_rq_data[p]);
		check_flag({tag, " req_full"}, i_mc_rq_stall[p], o_req_full[p]);
		check_flag({tag, " rd_vld"}, exp_rd_vld(i_mc_rs_vld[p], i_mc_rs_cmd[p]),
			o_rd_rsp_vld[p]);
		check_flag({tag, " wr_vld"}, exp_wr_vld(i_mc_rs_vld[p], i_mc_rs_cmd[p]),
			o_wr_rsp_vld[p]);
		check_flag({tag, " both_vld"}, 1'b0, o_rd_rsp_vld[p] && o_wr_rsp_vld[p]);
		check_tid({tag, " rd_tid"}, exp_rd_tid(i_mc_rs_cmd[p], i_mc_rs_scmd[p],
			i_mc_rs_rtnctl[p]), o_rd_rsp_tid[p]);
		check_data({tag, " rd_data"}, i_mc_rs_data[p], o_rd_rsp_data[p]);
		check_tid({tag, " wr_tid"}, i_mc_rs_rtnctl[p], o_wr_rsp_tid[p]);
		check_flag({tag, " rs_stall"}, i_rd_rsp_full[p] || i_wr_rsp_full[p],
			o_mc_rs_stall[p]);
	endtask

	task automatic finish_test();
		$display("%-12s %s (%0d errors)", test_name, (test_errs == 0) ? "pass" : "fail",
			test_errs);
		if (test_errs != 0)
			tests_failed++;
		total_errs += test_errs;
		test_errs = 0;
	endtask

	// Outputs sampled on the rising edge, half a period after the drive
	always @(posedge clk) begin
		for (int p = 0; p < NUM_MC_PORTS; p++) begin
			if (!i_rst_n)
				check_idle(p);
			else if (chk_en)
				check_port(p);
		end
	end

	initial begin
		seed = 32'h8ea6;
		chk_en = 1'b0;
		test_errs = 0;
		total_errs = 0;
		tests_failed = 0;
		test_name = "reset";
		i_rst_n = 1'b0;
		set_idle();
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		finish_test();
		i_rst_n = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_name = names[t];
			for (int v = 0; v < NUM_VEC; v++) begin
				@(negedge clk);
				for (int p = 0; p < NUM_MC_PORTS; p++)
					drive_port(t, v, p);
				chk_en = 1'b1;
			end
			@(negedge clk);
			chk_en = 1'b0;
			finish_test();
		end
		$display("Summary: %0d tests run, %0d failed, %0d errors", NUM_TESTS + 1,
			tests_failed, total_errs);
		if (tests_failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog sized from reset and vector count
	initial begin
		#((RST_CYCLES + NUM_TESTS * NUM_VEC + MARGIN) * CLK_PERIOD);
		$display("Watchdog expired before all tests completed");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+verification
logic/mc_adapter_pkg.sv
logic/mc_req_encoder.sv
logic/mc_rsp_decoder.sv
logic/mc_port_adapter.sv
verification/tb_mc_port_adapter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the port adapter testbench with Verilator

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_mc_port_adapter

rm -rf obj_dir "$LOG"

verilator --binary -j 0 -f flist.f --top-module "$TOP" -o "$TOP" 2>&1 | tee "$LOG" \
	&& ./obj_dir/"$TOP" 2>&1 | tee -a "$LOG" \
	|| { echo "Build or simulation exited with an error"; exit 1; }

# Any failure report in the log fails the run
grep -q "TESTS FAILED" "$LOG" \
	&& { echo "Simulation reported failures, see $LOG"; exit 1; }

echo "Simulation clean, see $LOG"
exit 0
